// ==== cache_pkg.sv ====
// ---------------------------------------------------------------------------
// shared widths and command encodings for the 2-way data cache
// ---------------------------------------------------------------------------
package cache_pkg;

	// address split [tag|group|word]
	localparam int BW_WORD_ADDR    = 12;               // word address width
	localparam int BW_BLOCK        = 2;                // word-in-block field
	localparam int WORDS_PER_BLOCK = 4;                // 2**BW_BLOCK

	// comm word, opcode in [31:30]
	typedef enum logic [1:0] {
		COMM_NOP   = 2'd0,                             // no action
		COMM_READ  = 2'd1,                             // selected counter onto comm_o
		COMM_CLEAR = 2'd2                              // zero all counters
	} comm_op_e;

	// comm word, counter select in [1:0]
	typedef enum logic [1:0] {
		CTR_HIT  = 2'd0,                               // first-lookup hits
		CTR_MISS = 2'd1,                               // first-lookup misses
		CTR_WB   = 2'd2                                // dirty block write-backs
	} ctr_sel_e;

endpackage

// ==== cache_ifs.sv ====
`timescale 1ns/1ps

// ---------------------------------------------------------------------------
// tag lookup path, controller <-> tag memory
// ---------------------------------------------------------------------------
interface tag_lookup_if #(
	parameter int BW_TAG = 6,
	parameter int BW_GRP = 4
);
	logic [BW_TAG-1:0] tag;                            // tag being looked up / installed
	logic [BW_GRP-1:0] group;                          // set index
	logic              update;                         // write tag, valid, dirty
	logic              upd_way;                        // way written on update
	logic              set_dirty;                      // dirty value on update
	logic              touch;                          // access marks way as MRU
	logic              hit;
	logic              hit_way;
	logic              victim_way;                     // invalid way first, else LRU
	logic [BW_TAG-1:0] victim_tag;
	logic              victim_dirty;

	modport ctrl (output tag, group, update, upd_way, set_dirty, touch,
		input hit, hit_way, victim_way, victim_tag, victim_dirty);
	modport mem (input tag, group, update, upd_way, set_dirty, touch,
		output hit, hit_way, victim_way, victim_tag, victim_dirty);
endinterface

// ---------------------------------------------------------------------------
// data array port, controller <-> data memory
// ---------------------------------------------------------------------------
interface data_mem_if #(
	parameter int BW_ADDR = 7
);
	logic [BW_ADDR-1:0] addr;                          // [way|group|word]
	logic               we;
	logic [31:0]        wdata;
	logic [31:0]        rdata;                         // valid one cycle after addr

	modport ctrl (output addr, we, wdata, input rdata);
	modport mem (input addr, we, wdata, output rdata);
endinterface

// ==== tag_memory_2way.sv ====
`timescale 1ns/1ps

module tag_memory_2way #(
	parameter int CACHE_BLOCK_CAPACITY = 32,
	localparam int NUM_SETS = CACHE_BLOCK_CAPACITY / 2,
	localparam int BW_GRP   = $clog2(CACHE_BLOCK_CAPACITY) - 1,
	localparam int BW_TAG   = cache_pkg::BW_WORD_ADDR - BW_GRP - cache_pkg::BW_BLOCK
)(
	input  logic       clock_i,
	input  logic       rst_n_i,
	tag_lookup_if.mem  lk
);

	logic [BW_TAG-1:0]         tag_mem [2][NUM_SETS];  // tag per way per set
	logic [NUM_SETS-1:0][1:0]  valid_r;                // [set][way]
	logic [NUM_SETS-1:0][1:0]  dirty_r;
	logic [NUM_SETS-1:0]       lru_r;                  // way to evict next
	logic [1:0]                match;
	logic                      victim;

	// lookup ----------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			match[w] = valid_r[lk.group][w] && (tag_mem[w][lk.group] == lk.tag);
		end
		if (!valid_r[lk.group][0])
			victim = 1'b0;                             // fill empty way first
		else if (!valid_r[lk.group][1])
			victim = 1'b1;
		else
			victim = lru_r[lk.group];
		lk.hit          = |match;
		lk.hit_way      = match[1];                    // at most one way matches
		lk.victim_way   = victim;
		lk.victim_tag   = tag_mem[victim][lk.group];
		lk.victim_dirty = valid_r[lk.group][victim] & dirty_r[lk.group][victim];
	end

	// tag written on install and on write hits
	always_ff @(posedge clock_i) begin
		if (lk.update)
			tag_mem[lk.upd_way][lk.group] <= lk.tag;
	end

	// state bits ------------------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_r <= '0;                             // all lines invalid
			dirty_r <= '0;
			lru_r   <= '0;
		end else begin
			if (lk.update) begin
				valid_r[lk.group][lk.upd_way] <= 1'b1;
				dirty_r[lk.group][lk.upd_way] <= lk.set_dirty;
			end
			if (lk.touch)
				lru_r[lk.group] <= ~lk.hit_way;        // other way becomes LRU
		end
	end

endmodule

// ==== data_memory.sv ====
`timescale 1ns/1ps

module data_memory #(
	parameter int CACHE_BLOCK_CAPACITY = 32,
	localparam int DEPTH   = CACHE_BLOCK_CAPACITY * cache_pkg::WORDS_PER_BLOCK,
	localparam int BW_ADDR = $clog2(DEPTH)
)(
	input  logic     clock_i,
	data_mem_if.mem  dm
);

	logic [31:0] mem [DEPTH];                          // word array [way|group|word]
	logic [31:0] rdata_r;

	// single port where a write cycle reads the old word
	always_ff @(posedge clock_i) begin
		if (dm.we)
			mem[dm.addr] <= dm.wdata;
		rdata_r <= mem[dm.addr];                       // registered read
	end

	assign dm.rdata = rdata_r;

endmodule

// ==== cache_2way_controller.sv ====
`timescale 1ns/1ps

module cache_2way_controller #(
	parameter int CACHE_BLOCK_CAPACITY = 32,
	localparam int BW_GRP   = $clog2(CACHE_BLOCK_CAPACITY) - 1,
	localparam int BW_TAG   = cache_pkg::BW_WORD_ADDR - BW_GRP - cache_pkg::BW_BLOCK,
	localparam int BW_BLK   = cache_pkg::BW_BLOCK
)(
	input  logic                            clock_i,
	input  logic                            rst_n_i,
	input  logic                            enable_i,     // request gate

	// core side
	input  logic                            core_req_i,   // one-cycle strobe
	input  logic                            core_rw_i,    // 1 write
	input  logic [BW_TAG-1:0]               core_tag_i,
	input  logic [BW_GRP-1:0]               core_grp_i,
	input  logic [BW_BLK-1:0]               core_word_i,
	input  logic [31:0]                     core_data_i,
	output logic                            core_done_o,
	output logic [31:0]                     core_data_o,
	output logic                            core_hit_o,   // first lookup result

	tag_lookup_if.ctrl                      lk,
	data_mem_if.ctrl                        dm,

	// external memory buffer
	input  logic                            ready_req_i,
	input  logic                            ready_write_i,
	input  logic                            ready_read_i,
	input  logic [31:0]                     data_i,
	output logic                            req_o,
	output logic                            rw_o,
	output logic                            write_o,
	output logic                            read_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0] add_o,     // block base address
	output logic [31:0]                     data_o,

	// performance flags pulse once per event
	output logic                            flag_hit_o,
	output logic                            flag_miss_o,
	output logic                            flag_writeback_o
);

	typedef enum logic [2:0] {
		S_IDLE, S_LOOKUP, S_ACCESS, S_WB_REQ, S_WB_WORDS, S_FILL_REQ, S_FILL_WORDS, S_RETRY
	} state_e;

	state_e              state_r;
	logic [BW_BLK-1:0]   blk_cnt_r;                    // word within block transfer
	logic                primed_r;                     // dm.rdata matches blk_cnt_r
	logic                vic_way_r;
	logic [BW_TAG-1:0]   vic_tag_r;
	logic                done_r;
	logic                hit_r;
	logic [31:0]         core_data_r;
	logic                blk_last;

	assign blk_last = (blk_cnt_r == {BW_BLK{1'b1}});

	// ------------------------------------------------------------------------
	// state register
	// ------------------------------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_r   <= S_IDLE;
			blk_cnt_r <= '0;
			primed_r  <= 1'b0;
			vic_way_r <= 1'b0;
			done_r    <= 1'b0;
			hit_r     <= 1'b0;
		end else begin
			done_r <= 1'b0;                            // done is a single pulse
			case (state_r)
				S_IDLE: begin
					if (core_req_i && enable_i)
						state_r <= S_LOOKUP;
				end
				S_LOOKUP, S_RETRY: begin
					if (state_r == S_LOOKUP)
						hit_r <= lk.hit;               // retry keeps first result
					if (lk.hit) begin
						state_r <= S_ACCESS;
					end else begin
						vic_way_r <= lk.victim_way;
						blk_cnt_r <= '0;
						state_r   <= lk.victim_dirty ? S_WB_REQ : S_FILL_REQ;
					end
				end
				S_ACCESS: begin
					done_r  <= 1'b1;                   // rdata valid this cycle
					state_r <= S_IDLE;
				end
				S_WB_REQ: begin
					if (ready_req_i) begin
						primed_r <= 1'b1;              // word 0 addressed during req
						state_r  <= S_WB_WORDS;
					end
				end
				S_WB_WORDS: begin
					if (write_o) begin
						primed_r  <= 1'b0;             // next word needs a read cycle
						blk_cnt_r <= blk_cnt_r + 1'b1;
						if (blk_last)
							state_r <= S_FILL_REQ;
					end else begin
						primed_r <= 1'b1;
					end
				end
				S_FILL_REQ: begin
					if (ready_req_i)
						state_r <= S_FILL_WORDS;
				end
				S_FILL_WORDS: begin
					if (read_o) begin
						blk_cnt_r <= blk_cnt_r + 1'b1; // wraps to 0
						if (blk_last)
							state_r <= S_RETRY;
					end
				end
				default: state_r <= S_IDLE;
			endcase
		end
	end

	// victim tag and read word capture
	always_ff @(posedge clock_i) begin
		if ((state_r == S_LOOKUP) && !lk.hit)
			vic_tag_r <= lk.victim_tag;
		if (state_r == S_ACCESS)
			core_data_r <= dm.rdata;
	end

	// ------------------------------------------------------------------------
	// outputs and lookup/data-memory drive
	// ------------------------------------------------------------------------
	always_comb begin
		lk.tag           = core_tag_i;
		lk.group         = core_grp_i;
		lk.update        = 1'b0;
		lk.upd_way       = lk.hit_way;
		lk.set_dirty     = 1'b0;
		lk.touch         = 1'b0;
		dm.addr          = {lk.hit_way, core_grp_i, core_word_i};
		dm.we            = 1'b0;
		dm.wdata         = core_data_i;
		req_o            = 1'b0;
		rw_o             = 1'b0;
		write_o          = 1'b0;
		read_o           = 1'b0;
		add_o            = {core_tag_i, core_grp_i, {BW_BLK{1'b0}}};
		flag_hit_o       = 1'b0;
		flag_miss_o      = 1'b0;
		flag_writeback_o = 1'b0;
		case (state_r)
			S_LOOKUP, S_RETRY: begin
				lk.touch     = lk.hit;
				lk.update    = lk.hit & core_rw_i;     // write hit marks dirty
				lk.set_dirty = 1'b1;
				dm.we        = lk.hit & core_rw_i;
				if (state_r == S_LOOKUP) begin
					flag_hit_o  = lk.hit;
					flag_miss_o = ~lk.hit;
				end
			end
			S_WB_REQ: begin
				req_o            = ready_req_i;
				rw_o             = 1'b1;
				add_o            = {vic_tag_r, core_grp_i, {BW_BLK{1'b0}}};
				dm.addr          = {vic_way_r, core_grp_i, blk_cnt_r};
				flag_writeback_o = ready_req_i;
			end
			S_WB_WORDS: begin
				write_o = ready_write_i & primed_r;
				dm.addr = {vic_way_r, core_grp_i, blk_cnt_r};
			end
			S_FILL_REQ: begin
				req_o = ready_req_i;                   // add_o is the missing block
			end
			S_FILL_WORDS: begin
				read_o     = ready_read_i;
				dm.addr    = {vic_way_r, core_grp_i, blk_cnt_r};
				dm.we      = ready_read_i;
				dm.wdata   = data_i;
				lk.update  = ready_read_i & blk_last;  // install clean tag
				lk.upd_way = vic_way_r;
			end
			default: ;
		endcase
	end

	assign data_o      = dm.rdata;                     // write-back word
	assign core_done_o = done_r;
	assign core_data_o = core_data_r;
	assign core_hit_o  = hit_r;

endmodule

// ==== cache_performance_controller.sv ====
`timescale 1ns/1ps

module cache_performance_controller (
	input  logic        clock_i,
	input  logic        rst_n_i,
	input  logic        hit_i,                         // pulse per first-lookup hit
	input  logic        miss_i,                        // pulse per first-lookup miss
	input  logic        writeback_i,                   // pulse per block write-back
	input  logic [31:0] comm_i,                        // [31:30] op, [1:0] select
	output logic [31:0] comm_o
);

	logic [2:0][31:0]        ctr_r;                    // indexed by ctr_sel_e
	logic [2:0]              event_w;
	cache_pkg::comm_op_e     op_w;
	cache_pkg::ctr_sel_e     sel_w;

	assign event_w = {writeback_i, miss_i, hit_i};
	assign op_w    = cache_pkg::comm_op_e'(comm_i[31:30]);
	assign sel_w   = cache_pkg::ctr_sel_e'(comm_i[1:0]);

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctr_r  <= '0;
			comm_o <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (event_w[i] && (ctr_r[i] != '1))
					ctr_r[i] <= ctr_r[i] + 1'b1;   // saturate at all ones
			end
			case (op_w)
				cache_pkg::COMM_READ: begin
					case (sel_w)
						cache_pkg::CTR_HIT:  comm_o <= ctr_r[0];
						cache_pkg::CTR_MISS: comm_o <= ctr_r[1];
						cache_pkg::CTR_WB:   comm_o <= ctr_r[2];
						default:             comm_o <= '0;
					endcase
				end
				cache_pkg::COMM_CLEAR: ctr_r <= '0;  // clear wins over same-cycle events
				cache_pkg::COMM_NOP: ;               // comm_o holds last read
				default: ;
			endcase
		end
	end

endmodule

// ==== cache_2way.sv ====
`timescale 1ns/1ps

module cache_2way #(
	parameter int CACHE_BLOCK_CAPACITY = 32
)(
	input  logic                              clock_i,
	input  logic                              rst_n_i,
	input  logic                              en_i,           // cache enable
	input  logic [31:0]                       comm_i,         // counter command
	output logic [31:0]                       comm_o,

	// core
	input  logic                              core_req_i,
	input  logic                              core_rw_i,
	input  logic [cache_pkg::BW_WORD_ADDR-1:0] core_add_i,
	input  logic [31:0]                       core_data_i,
	output logic                              core_done_o,
	output logic [31:0]                       core_data_o,
	output logic                              hit_o,

	// external memory buffer
	input  logic                              ready_req_i,
	input  logic                              ready_write_i,
	input  logic                              ready_read_i,
	input  logic [31:0]                       data_i,
	output logic                              req_o,
	output logic                              rw_o,
	output logic                              write_o,
	output logic                              read_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0] add_o,
	output logic [31:0]                       data_o
);

	localparam int BW_GRP   = $clog2(CACHE_BLOCK_CAPACITY) - 1;   // one bit goes to way
	localparam int BW_TAG   = cache_pkg::BW_WORD_ADDR - BW_GRP - cache_pkg::BW_BLOCK;
	localparam int BW_DADDR = $clog2(CACHE_BLOCK_CAPACITY) + cache_pkg::BW_BLOCK;

	// address split -----------------------------------------------------------
	logic [BW_TAG-1:0]              req_tag;
	logic [BW_GRP-1:0]              req_group;
	logic [cache_pkg::BW_BLOCK-1:0] req_word;
	logic                           hit_flag;
	logic                           miss_flag;
	logic                           wb_flag;

	assign {req_tag, req_group, req_word} = core_add_i;

	tag_lookup_if #(.BW_TAG(BW_TAG), .BW_GRP(BW_GRP)) tag_lk ();
	data_mem_if #(.BW_ADDR(BW_DADDR)) dmem ();

	// blocks ----------------------------------------------------------------
	tag_memory_2way #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) tag_mem_i (
		.clock_i (clock_i),
		.rst_n_i (rst_n_i),
		.lk      (tag_lk.mem)
	);

	data_memory #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) data_mem_i (
		.clock_i (clock_i),
		.dm      (dmem.mem)
	);

	cache_2way_controller #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) ctrl_i (
		.clock_i          (clock_i),
		.rst_n_i          (rst_n_i),
		.enable_i         (en_i),
		.core_req_i       (core_req_i),
		.core_rw_i        (core_rw_i),
		.core_tag_i       (req_tag),
		.core_grp_i       (req_group),
		.core_word_i      (req_word),
		.core_data_i      (core_data_i),
		.core_done_o      (core_done_o),
		.core_data_o      (core_data_o),
		.core_hit_o       (hit_o),
		.lk               (tag_lk.ctrl),
		.dm               (dmem.ctrl),
		.ready_req_i      (ready_req_i),
		.ready_write_i    (ready_write_i),
		.ready_read_i     (ready_read_i),
		.data_i           (data_i),
		.req_o            (req_o),
		.rw_o             (rw_o),
		.write_o          (write_o),
		.read_o           (read_o),
		.add_o            (add_o),
		.data_o           (data_o),
		.flag_hit_o       (hit_flag),
		.flag_miss_o      (miss_flag),
		.flag_writeback_o (wb_flag)
	);

	cache_performance_controller perf_i (
		.clock_i     (clock_i),
		.rst_n_i     (rst_n_i),
		.hit_i       (hit_flag),
		.miss_i      (miss_flag),
		.writeback_i (wb_flag),
		.comm_i      (comm_i),
		.comm_o      (comm_o)
	);

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
	input  logic                               clock_i,
	input  logic                               rst_n_i,
	input  logic                               req_i,          // block request strobe
	input  logic                               write_i,        // write-back word strobe
	input  logic                               read_i,         // fill word strobe
	input  logic [cache_pkg::BW_WORD_ADDR-1:0] add_i,          // block base address
	input  logic [31:0]                        data_i,         // write-back word
	output logic                               ready_req_o,
	output logic                               ready_write_o,
	output logic                               ready_read_o,
	output logic [31:0]                        data_o          // fill word
);

	logic [31:0] mem [4096];                           // whole word address space
	logic [11:0] base_r;                               // current block base
	logic [1:0]  idx_r;                                // word within block
	integer      seed;

	initial begin
		seed = 48176;
		for (int a = 0; a < 4096; a++)
			mem[a] = {8'hd5, a[11:0], ~a[11:0]};      // every address bit shows
		ready_req_o   = 1'b0;
		ready_write_o = 1'b0;
		ready_read_o  = 1'b0;
		data_o        = 32'd0;
	end

	// transfer bookkeeping, words move in block order
	always @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			base_r <= 12'd0;
			idx_r  <= 2'd0;
		end else begin
			if (req_i) begin
				base_r <= {add_i[11:2], 2'b00};
				idx_r  <= 2'd0;
			end
			if (write_i) begin
				mem[{base_r[11:2], idx_r}] = data_i;  // store write-back word
				idx_r <= idx_r + 2'd1;
			end
			if (read_i)
				idx_r <= idx_r + 2'd1;
		end
	end

	// ready levels and fill word change on the falling edge
	always @(negedge clock_i) begin
		if (!rst_n_i) begin
			ready_req_o   = 1'b0;
			ready_write_o = 1'b0;
			ready_read_o  = 1'b0;
		end else begin
			ready_req_o   = ($random(seed) & 3) != 0;  // about three in four cycles
			ready_write_o = ($random(seed) & 3) != 0;
			ready_read_o  = ($random(seed) & 3) != 0;
		end
		data_o = mem[{base_r[11:2], idx_r}];
	end

endmodule

// ==== tb_cache_2way.sv ====
`timescale 1ns/1ps

module tb_cache_2way;

	localparam int CLK_PERIOD    = 4;
	localparam int NUM_SETS      = 16;                 // 32 blocks, 2 ways
	localparam int DIRECTED_REQS = 20;
	localparam int RANDOM_REQS   = 300;
	localparam int MISS_BOUND    = 200;                // cycles, throttled write-back plus fill

	logic        clock = 1'b0;
	logic        rst_n;
	logic        en;
	logic        core_req;
	logic        core_rw;
	logic [11:0] core_add;
	logic [31:0] core_wdata;
	logic [31:0] core_rdata;
	logic        core_done;
	logic        hit;
	logic [31:0] comm_in;
	logic [31:0] comm_out;
	logic        ready_req;
	logic        ready_write;
	logic        ready_read;
	logic [31:0] mem_rdata;
	logic [31:0] mem_wdata;
	logic        req;
	logic        rw;
	logic        write;
	logic        read;
	logic [11:0] add;

	// reference cache state -------------------------------------------------
	logic [5:0]  ref_tag   [2][NUM_SETS];
	logic        ref_valid [2][NUM_SETS];
	logic        ref_dirty [2][NUM_SETS];
	logic        ref_lru   [NUM_SETS];               // way to evict next
	logic [31:0] ref_line  [2][NUM_SETS][4];
	logic [31:0] ref_mem   [4096];                   // memory after predicted write-backs
	logic [11:0] wb_expected [$];                    // predicted write-back bases
	logic [11:0] wb_exp_add;
	logic [11:0] last_wb_add;
	int          ref_hits;
	int          ref_misses;
	int          ref_wbs;
	int          wb_seen;
	int          checks;
	int          errors;
	integer      seed;

	always #(CLK_PERIOD / 2) clock = ~clock;

	cache_2way #(.CACHE_BLOCK_CAPACITY(32)) dut_i (
		.clock_i (clock), .rst_n_i (rst_n), .en_i (en),
		.comm_i (comm_in), .comm_o (comm_out),
		.core_req_i (core_req), .core_rw_i (core_rw), .core_add_i (core_add),
		.core_data_i (core_wdata), .core_done_o (core_done), .core_data_o (core_rdata),
		.hit_o (hit),
		.ready_req_i (ready_req), .ready_write_i (ready_write), .ready_read_i (ready_read),
		.data_i (mem_rdata), .req_o (req), .rw_o (rw), .write_o (write), .read_o (read),
		.add_o (add), .data_o (mem_wdata)
	);

	tb_mem_model mem_i (
		.clock_i (clock), .rst_n_i (rst_n), .req_i (req), .write_i (write), .read_i (read),
		.add_i (add), .data_i (mem_wdata), .ready_req_o (ready_req),
		.ready_write_o (ready_write), .ready_read_o (ready_read), .data_o (mem_rdata)
	);

	function automatic logic [11:0] blk_addr(input logic [5:0] t, input logic [3:0] g,
		input logic [1:0] w);
		return {t, g, w};                              // [tag|group|word]
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// 2-way LRU write-back, write-allocate prediction
	task automatic ref_access(input logic [11:0] a, input logic w_en, input logic [31:0] wdata,
		output logic hit_exp, output logic [31:0] rdata_exp);
		logic [5:0] t;
		logic [3:0] g;
		logic       way;
		t       = a[11:6];
		g       = a[5:2];
		way     = 1'b0;
		hit_exp = 1'b0;
		for (int i = 0; i < 2; i++) begin
			if (ref_valid[i][g] && ref_tag[i][g] == t) begin
				hit_exp = 1'b1;
				way     = i[0];
			end
		end
		if (hit_exp) begin
			ref_hits++;
		end else begin
			ref_misses++;
			way = !ref_valid[0][g] ? 1'b0 : (!ref_valid[1][g] ? 1'b1 : ref_lru[g]);
			if (ref_valid[way][g] && ref_dirty[way][g]) begin
				ref_wbs++;
				wb_expected.push_back({ref_tag[way][g], g, 2'b00});
				for (int i = 0; i < 4; i++)
					ref_mem[{ref_tag[way][g], g, i[1:0]}] = ref_line[way][g][i];
			end
			for (int i = 0; i < 4; i++)
				ref_line[way][g][i] = ref_mem[{t, g, i[1:0]}];  // fill
			ref_tag[way][g]   = t;
			ref_valid[way][g] = 1'b1;
			ref_dirty[way][g] = 1'b0;
		end
		rdata_exp = ref_line[way][g][a[1:0]];
		if (w_en) begin
			ref_line[way][g][a[1:0]] = wdata;
			ref_dirty[way][g]        = 1'b1;
		end
		ref_lru[g] = ~way;                             // other way is now LRU
	endtask

	// one core request, checked against the reference
	task automatic cache_access(input logic [11:0] a, input logic w_en, input logic [31:0] wdata,
		output logic got_hit);
		logic        exp_hit;
		logic [31:0] exp_data;
		int          cycles;
		ref_access(a, w_en, wdata, exp_hit, exp_data);
		@(negedge clock);
		core_req   = 1'b1;
		core_rw    = w_en;
		core_add   = a;
		core_wdata = wdata;
		@(negedge clock);
		core_req = 1'b0;                               // one-cycle strobe
		cycles   = 1;
		while (!core_done && cycles < MISS_BOUND) begin
			@(negedge clock);
			cycles++;
		end
		got_hit = hit;
		if (!core_done) begin
			errors++;
			$display("no core_done_o within %0d cycles for address %h", MISS_BOUND, a);
		end else begin
			check_value({31'd0, hit}, {31'd0, exp_hit}, "hit_o");
			if (exp_hit)
				check_value(32'(cycles - 1), 32'd2, "hit latency");  // edges after sampling
			if (!w_en)
				check_value(core_rdata, exp_data, "read data");
		end
	endtask

	task automatic compare_memory();
		int bad;
		bad = 0;
		for (int a = 0; a < 4096; a++) begin
			if (mem_i.mem[a] !== ref_mem[a])
				bad++;
		end
		checks++;
		assert (bad == 0) else begin
			errors++;
			$display("mismatch at %0t: %0d memory words differ from reference", $time, bad);
		end
	endtask

	task automatic read_counter(input cache_pkg::ctr_sel_e sel, input int exp, input string what);
		@(negedge clock);
		comm_in = {cache_pkg::COMM_READ, 28'd0, sel};
		@(negedge clock);
		comm_in = 32'd0;                               // comm_o registered one cycle later
		check_value(comm_out, 32'(exp), what);
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		if (errors == errs_at_start)
			$display("test %s: ok", name);
		else
			$display("test %s: FAILED, %0d errors", name, errors - errs_at_start);
	endtask

	// write-back requests against the predicted victims ---------------------
	always @(posedge clock) begin
		if (req && rw) begin
			wb_seen++;
			last_wb_add = add;
			if (wb_expected.size() == 0) begin
				errors++;
				$display("write-back request at %0t with none predicted, block %h", $time, add);
			end else begin
				wb_exp_add = wb_expected.pop_front();
				check_value({20'd0, add}, {20'd0, wb_exp_add}, "write-back add_o");
			end
		end
	end

	// watchdog, every request at worst-case miss time
	initial begin
		#((DIRECTED_REQS + RANDOM_REQS) * MISS_BOUND * CLK_PERIOD);
		$display("timeout, the run did not finish within its request budget");
		$display("Verification failed");
		$finish;
	end

	initial begin
		logic        got_hit;
		logic [31:0] rnd;
		int          errs;
		int          wb_before;
		seed       = 48176;
		rst_n      = 1'b0;
		en         = 1'b0;
		core_req   = 1'b0;
		core_rw    = 1'b0;
		core_add   = 12'd0;
		core_wdata = 32'd0;
		comm_in    = 32'd0;
		checks     = 0;
		errors     = 0;
		ref_hits   = 0;
		ref_misses = 0;
		ref_wbs    = 0;
		wb_seen    = 0;
		for (int s = 0; s < NUM_SETS; s++) begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				ref_valid[w][s] = 1'b0;
				ref_dirty[w][s] = 1'b0;
			end
		end
		for (int a = 0; a < 4096; a++)
			ref_mem[a] = {8'hd5, a[11:0], ~a[11:0]};   // same fill rule as memory
		repeat (4) @(negedge clock);
		rst_n = 1'b1;
		en    = 1'b1;

		// cold read, then a hit in the same block
		errs = errors;
		cache_access(blk_addr(6'd1, 4'd3, 2'd1), 1'b0, 32'd0, got_hit);
		check_value({31'd0, got_hit}, 32'd0, "cold read hit_o");
		cache_access(blk_addr(6'd1, 4'd3, 2'd2), 1'b0, 32'd0, got_hit);
		check_value({31'd0, got_hit}, 32'd1, "second read hit_o");
		report_test("1 cold read then hit", errs);

		// write hit then read back
		errs = errors;
		cache_access(blk_addr(6'd1, 4'd3, 2'd0), 1'b1, 32'hcafe_0001, got_hit);
		cache_access(blk_addr(6'd1, 4'd3, 2'd0), 1'b0, 32'd0, got_hit);
		report_test("2 write hit read back", errs);

		// dirty victim goes back to memory
		errs      = errors;
		wb_before = wb_seen;
		cache_access(blk_addr(6'd2, 4'd5, 2'd0), 1'b0, 32'd0, got_hit);
		cache_access(blk_addr(6'd2, 4'd5, 2'd1), 1'b1, 32'h1111_aaaa, got_hit);
		cache_access(blk_addr(6'd2, 4'd5, 2'd3), 1'b1, 32'h3333_cccc, got_hit);
		cache_access(blk_addr(6'd3, 4'd5, 2'd0), 1'b0, 32'd0, got_hit);
		cache_access(blk_addr(6'd4, 4'd5, 2'd2), 1'b0, 32'd0, got_hit);
		check_value(32'(wb_seen - wb_before), 32'd1, "write-back count");
		check_value({20'd0, last_wb_add}, {20'd0, blk_addr(6'd2, 4'd5, 2'd0)}, "write-back base");
		check_value(mem_i.mem[blk_addr(6'd2, 4'd5, 2'd1)], 32'h1111_aaaa, "written word 1");
		check_value(mem_i.mem[blk_addr(6'd2, 4'd5, 2'd3)], 32'h3333_cccc, "written word 3");
		compare_memory();
		report_test("3 dirty write-back", errs);

		// LRU order A B A C in set 7
		errs = errors;
		cache_access(blk_addr(6'd5, 4'd7, 2'd0), 1'b0, 32'd0, got_hit);
		cache_access(blk_addr(6'd6, 4'd7, 2'd0), 1'b0, 32'd0, got_hit);
		cache_access(blk_addr(6'd5, 4'd7, 2'd1), 1'b0, 32'd0, got_hit);
		cache_access(blk_addr(6'd7, 4'd7, 2'd0), 1'b0, 32'd0, got_hit);
		cache_access(blk_addr(6'd5, 4'd7, 2'd2), 1'b0, 32'd0, got_hit);
		check_value({31'd0, got_hit}, 32'd1, "tag A after C hit_o");
		cache_access(blk_addr(6'd6, 4'd7, 2'd0), 1'b0, 32'd0, got_hit);
		check_value({31'd0, got_hit}, 32'd0, "tag B after C hit_o");
		report_test("4 LRU order", errs);

		// random stream under throttled memory
		errs = errors;
		for (int n = 0; n < RANDOM_REQS; n++) begin
			rnd = $random(seed);
			cache_access({3'b000, rnd[2:0], rnd[7:4], rnd[9:8]}, rnd[12], $random(seed), got_hit);
		end
		compare_memory();
		check_value(32'(wb_seen), 32'(ref_wbs), "total write-backs");
		report_test("5 random stream", errs);

		// performance counters, read then clear
		errs = errors;
		read_counter(cache_pkg::CTR_HIT, ref_hits, "hit counter");
		read_counter(cache_pkg::CTR_MISS, ref_misses, "miss counter");
		read_counter(cache_pkg::CTR_WB, ref_wbs, "write-back counter");
		@(negedge clock);
		comm_in = {cache_pkg::COMM_CLEAR, 30'd0};
		@(negedge clock);
		comm_in = 32'd0;
		read_counter(cache_pkg::CTR_HIT, 0, "cleared hit counter");
		read_counter(cache_pkg::CTR_MISS, 0, "cleared miss counter");
		read_counter(cache_pkg::CTR_WB, 0, "cleared write-back counter");
		report_test("6 performance counters", errs);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== cache_2way.f ====
cache_pkg.sv
cache_ifs.sv
tag_memory_2way.sv
data_memory.sv
cache_2way_controller.sv
cache_performance_controller.sv
cache_2way.sv
tb_mem_model.sv
tb_cache_2way.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_2way -f cache_2way.f &&
./obj_dir/Vtb_cache_2way | tee /dev/stderr | grep -q "^Verification passed$" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
